/* design/wb_types_pkg.sv */
// write-back data path types

package wb_types_pkg;

    // ==============================
    // field widths
    // ==============================

    // register file data word
    localparam int REG_DATA_W = 32;

    // architectural register index, zero is "no destination"
    localparam int REG_ADDR_W = 5;

    // tag handed back to the hazard logic on completion
    localparam int COMMIT_ID_W = 4;

    // program-order stamp, smaller is older, no wrap handling
    localparam int TS_W = 8;

    // ==============================
    // vector types
    // ==============================

    typedef logic [REG_DATA_W-1:0] reg_data_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

    typedef logic [TS_W-1:0] timestamp_t;

    // the x0 index doubles as the empty issue slot
    localparam reg_addr_t REG_NONE = '0;

endpackage

/* design/wb_src_pkg.sv */
// execution source identities

package wb_src_pkg;

    // lsu, div, mul and alu
    localparam int N_SRC = 4;

    localparam int SRC_IDX_W = $clog2(N_SRC);

    // encoding is also the fixed priority, higher value wins
    typedef enum logic [SRC_IDX_W-1:0] {
        SRC_ALU = 0,
        SRC_MUL = 1,
        SRC_DIV = 2,
        SRC_LSU = 3
    } src_e;

    // one bit per source, indexed by src_e
    typedef logic [N_SRC-1:0] src_vec_t;

    // highest priority source, where the arbiter starts its scan
    localparam src_e SRC_TOP = SRC_LSU;

endpackage

/* design/wb_req_if.sv */
// source write-back requests
`timescale 1ns/1ps

interface wb_req_if;

    import wb_types_pkg::*;
    import wb_src_pkg::*;

    // request level per source, held until ready
    src_vec_t                   we;
    reg_addr_t  [N_SRC-1:0]     waddr;
    timestamp_t [N_SRC-1:0]     ts;
    reg_data_t  [N_SRC-1:0]     wdata;
    commit_id_t [N_SRC-1:0]     commit_id;

    // in-flight lookup only needs the hazard fields
    modport table_mp (
        input we,
        input waddr,
        input ts
    );

    // same-cycle compare
    modport check_mp (
        input we,
        input waddr,
        input ts
    );

    // arbiter forwards payload to the register ports
    modport arb_mp (
        input we,
        input waddr,
        input ts,
        input wdata,
        input commit_id
    );

endinterface

/* design/wb_retire_if.sv */
// granted writes fed back to the in-flight table
`timescale 1ns/1ps

interface wb_retire_if;

    import wb_types_pkg::*;

    // index 0 is channel 1, index 1 is channel 2
    logic       [1:0] valid;
    reg_addr_t  [1:0] waddr;
    timestamp_t [1:0] ts;

    modport arb_mp (
        output valid,
        output waddr,
        output ts
    );

    modport table_mp (
        input valid,
        input waddr,
        input ts
    );

endinterface

/* design/inflight_table.sv */
// in-flight destination table
`timescale 1ns/1ps

module inflight_table #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  wb_types_pkg::reg_addr_t inst1_rd_addr_i,
    input  wb_types_pkg::reg_addr_t inst2_rd_addr_i,
    input  wb_types_pkg::timestamp_t inst1_ts_i,
    input  wb_types_pkg::timestamp_t inst2_ts_i,
    wb_req_if.table_mp              req,
    wb_retire_if.table_mp           retire,
    output wb_src_pkg::src_vec_t    older_pending_o
);

    import wb_types_pkg::*;
    import wb_src_pkg::*;

    logic       [TABLE_DEPTH-1:0] valid_q;
    reg_addr_t  [TABLE_DEPTH-1:0] addr_q;
    timestamp_t [TABLE_DEPTH-1:0] ts_q;

    // one-hot slot picks for the two announcements
    logic [TABLE_DEPTH-1:0] alloc1;
    logic [TABLE_DEPTH-1:0] alloc2;
    logic [TABLE_DEPTH-1:0] retire_hit;
    logic                   ann_drop;

    // ==============================
    // allocation
    // ==============================

    // inst1 gets the lowest free slot, inst2 the next one
    always_comb begin
        logic need1;
        logic need2;
        need1  = (inst1_rd_addr_i != REG_NONE);
        need2  = (inst2_rd_addr_i != REG_NONE);
        alloc1 = '0;
        alloc2 = '0;
        for (int e = 0; e < TABLE_DEPTH; e++) begin
            if (!valid_q[e]) begin
                if (need1) begin
                    alloc1[e] = 1'b1;
                    need1     = 1'b0;
                end else if (need2) begin
                    alloc2[e] = 1'b1;
                    need2     = 1'b0;
                end
            end
        end
        // table full, the leftover announcement is lost
        ann_drop = need1 || need2;
    end

    // an entry retires when address and stamp both match
    always_comb begin
        retire_hit = '0;
        for (int e = 0; e < TABLE_DEPTH; e++) begin
            for (int c = 0; c < 2; c++) begin
                if (valid_q[e] && retire.valid[c] &&
                    addr_q[e] == retire.waddr[c] && ts_q[e] == retire.ts[c]) begin
                    retire_hit[e] = 1'b1;
                end
            end
        end
    end

    // ==============================
    // table state
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~retire_hit) | alloc1 | alloc2;
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < TABLE_DEPTH; e++) begin
            if (alloc1[e]) begin
                addr_q[e] <= inst1_rd_addr_i;
                ts_q[e]   <= inst1_ts_i;
            end else if (alloc2[e]) begin
                addr_q[e] <= inst2_rd_addr_i;
                ts_q[e]   <= inst2_ts_i;
            end
        end
    end

    // ==============================
    // older write lookup
    // ==============================

    // the request's own entry has an equal stamp and never blocks it
    always_comb begin
        older_pending_o = '0;
        for (int s = 0; s < N_SRC; s++) begin
            for (int e = 0; e < TABLE_DEPTH; e++) begin
                if (req.we[s] && valid_q[e] &&
                    addr_q[e] == req.waddr[s] && ts_q[e] < req.ts[s]) begin
                    older_pending_o[s] = 1'b1;
                end
            end
        end
    end

    // issue must not announce more destinations than the table can hold
    a_no_drop: assert property (
        @(posedge clk) disable iff (!rst_n)
        !flush_i |-> !ann_drop
    ) else $error("inflight_table: announcement dropped, table full");

endmodule

/* design/same_cycle_check.sv */
// same-cycle WAW detection
`timescale 1ns/1ps

module same_cycle_check (
    wb_req_if.check_mp           req,
    output wb_src_pkg::src_vec_t younger_lose_o
);

    import wb_src_pkg::*;

    // some unmarked requester to the same register exists
    src_vec_t has_winner;

    // younger of each same-register pair waits, a tie goes to priority
    always_comb begin
        younger_lose_o = '0;
        for (int i = 0; i < N_SRC; i++) begin
            for (int j = i + 1; j < N_SRC; j++) begin
                if (req.we[i] && req.we[j] && req.waddr[i] == req.waddr[j]) begin
                    if (req.ts[i] > req.ts[j]) begin
                        younger_lose_o[i] = 1'b1;
                    end else if (req.ts[j] > req.ts[i]) begin
                        younger_lose_o[j] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        has_winner = '0;
        for (int i = 0; i < N_SRC; i++) begin
            for (int j = 0; j < N_SRC; j++) begin
                if (req.we[j] && !younger_lose_o[j] && req.waddr[i] == req.waddr[j]) begin
                    has_winner[i] = 1'b1;
                end
            end
        end
    end

    // the oldest writer of a register always stays eligible here
    always_comb begin
        a_oldest_kept: assert final ((req.we & ~has_winner) == '0)
            else $error("same_cycle_check: every writer of a register held back");
    end

endmodule

/* design/wb_arbiter.sv */
// two-port write-back arbiter
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                      flush_i,
    wb_req_if.arb_mp                  req,
    input  wb_src_pkg::src_vec_t      older_pending_i,
    input  wb_src_pkg::src_vec_t      younger_lose_i,
    wb_retire_if.arb_mp               retire,
    output wb_src_pkg::src_vec_t      ready_o,
    output logic                      reg1_we_o,
    output logic                      reg2_we_o,
    output wb_types_pkg::reg_addr_t   reg1_waddr_o,
    output wb_types_pkg::reg_addr_t   reg2_waddr_o,
    output wb_types_pkg::reg_data_t   reg1_wdata_o,
    output wb_types_pkg::reg_data_t   reg2_wdata_o,
    output logic                      commit_valid1_o,
    output logic                      commit_valid2_o,
    output wb_types_pkg::commit_id_t  commit_id1_o,
    output wb_types_pkg::commit_id_t  commit_id2_o
);

    import wb_types_pkg::*;
    import wb_src_pkg::*;

    src_vec_t eligible;
    src_e     sel1;
    src_e     sel2;
    logic     found1;
    logic     found2;
    logic     grant1;
    logic     grant2;

    // ==============================
    // selection
    // ==============================

    assign eligible = req.we & ~older_pending_i & ~younger_lose_i;

    // scan from lsu down, first hit is channel 1, second is channel 2
    always_comb begin
        found1 = 1'b0;
        found2 = 1'b0;
        sel1   = SRC_ALU;
        sel2   = SRC_ALU;
        for (int s = int'(SRC_TOP); s >= 0; s--) begin
            if (eligible[s]) begin
                if (!found1) begin
                    found1 = 1'b1;
                    sel1   = src_e'(s);
                end else if (!found2) begin
                    found2 = 1'b1;
                    sel2   = src_e'(s);
                end
            end
        end
    end

    // flush kills both channels outright
    assign grant1 = found1 && !flush_i;
    assign grant2 = found2 && !flush_i;

    // ready means consumed this cycle
    always_comb begin
        ready_o = '0;
        if (grant1) begin
            ready_o[sel1] = 1'b1;
        end
        if (grant2) begin
            ready_o[sel2] = 1'b1;
        end
    end

    // ==============================
    // register and commit ports
    // ==============================

    assign reg1_we_o       = grant1;
    assign reg1_waddr_o    = grant1 ? req.waddr[sel1] : '0;
    assign reg1_wdata_o    = grant1 ? req.wdata[sel1] : '0;
    assign commit_valid1_o = grant1;
    assign commit_id1_o    = grant1 ? req.commit_id[sel1] : '0;

    assign reg2_we_o       = grant2;
    assign reg2_waddr_o    = grant2 ? req.waddr[sel2] : '0;
    assign reg2_wdata_o    = grant2 ? req.wdata[sel2] : '0;
    assign commit_valid2_o = grant2;
    assign commit_id2_o    = grant2 ? req.commit_id[sel2] : '0;

    // table clears the matching entries at the next edge
    assign retire.valid = {grant2, grant1};
    assign retire.waddr = {reg2_waddr_o, reg1_waddr_o};
    assign retire.ts    = {grant2 ? req.ts[sel2] : '0, grant1 ? req.ts[sel1] : '0};

    // both ports on one register only for an equal-stamp tie
    always_comb begin
        a_port_waw: assert final (!(reg1_we_o && reg2_we_o &&
                                    reg1_waddr_o == reg2_waddr_o) ||
                                  retire.ts[0] == retire.ts[1])
            else $error("wb_arbiter: both ports write one register out of order");
    end

endmodule

/* design/writeback_unit.sv */
// dual-port register write-back stage
`timescale 1ns/1ps

module writeback_unit #(
    parameter int TABLE_DEPTH = 8
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               flush_i,
    // execution sources
    input  wb_src_pkg::src_vec_t                               src_we_i,
    input  wb_types_pkg::reg_addr_t  [wb_src_pkg::N_SRC-1:0]   src_waddr_i,
    input  wb_types_pkg::timestamp_t [wb_src_pkg::N_SRC-1:0]   src_ts_i,
    input  wb_types_pkg::reg_data_t  [wb_src_pkg::N_SRC-1:0]   src_wdata_i,
    input  wb_types_pkg::commit_id_t [wb_src_pkg::N_SRC-1:0]   src_commit_id_i,
    output wb_src_pkg::src_vec_t                               src_ready_o,
    // issue announcements
    input  wb_types_pkg::reg_addr_t                            inst1_rd_addr_i,
    input  wb_types_pkg::reg_addr_t                            inst2_rd_addr_i,
    input  wb_types_pkg::timestamp_t                           inst1_ts_i,
    input  wb_types_pkg::timestamp_t                           inst2_ts_i,
    // register file ports
    output logic                                               reg1_we_o,
    output logic                                               reg2_we_o,
    output wb_types_pkg::reg_addr_t                            reg1_waddr_o,
    output wb_types_pkg::reg_addr_t                            reg2_waddr_o,
    output wb_types_pkg::reg_data_t                            reg1_wdata_o,
    output wb_types_pkg::reg_data_t                            reg2_wdata_o,
    // completion to hazard logic
    output logic                                               commit_valid1_o,
    output logic                                               commit_valid2_o,
    output wb_types_pkg::commit_id_t                           commit_id1_o,
    output wb_types_pkg::commit_id_t                           commit_id2_o
);

    import wb_src_pkg::*;

    src_vec_t older_pending;
    src_vec_t younger_lose;

    wb_req_if    req_bus ();
    wb_retire_if retire_bus ();

    assign req_bus.we        = src_we_i;
    assign req_bus.waddr     = src_waddr_i;
    assign req_bus.ts        = src_ts_i;
    assign req_bus.wdata     = src_wdata_i;
    assign req_bus.commit_id = src_commit_id_i;

    inflight_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) inflight_table_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .inst1_rd_addr_i (inst1_rd_addr_i),
        .inst2_rd_addr_i (inst2_rd_addr_i),
        .inst1_ts_i      (inst1_ts_i),
        .inst2_ts_i      (inst2_ts_i),
        .req             (req_bus.table_mp),
        .retire          (retire_bus.table_mp),
        .older_pending_o (older_pending)
    );

    same_cycle_check same_cycle_check_i (
        .req            (req_bus.check_mp),
        .younger_lose_o (younger_lose)
    );

    wb_arbiter wb_arbiter_i (
        .flush_i         (flush_i),
        .req             (req_bus.arb_mp),
        .older_pending_i (older_pending),
        .younger_lose_i  (younger_lose),
        .retire          (retire_bus.arb_mp),
        .ready_o         (src_ready_o),
        .reg1_we_o       (reg1_we_o),
        .reg2_we_o       (reg2_we_o),
        .reg1_waddr_o    (reg1_waddr_o),
        .reg2_waddr_o    (reg2_waddr_o),
        .reg1_wdata_o    (reg1_wdata_o),
        .reg2_wdata_o    (reg2_wdata_o),
        .commit_valid1_o (commit_valid1_o),
        .commit_valid2_o (commit_valid2_o),
        .commit_id1_o    (commit_id1_o),
        .commit_id2_o    (commit_id2_o)
    );

endmodule

/* sim/wb_ref_model.svh */
// write-back reference model
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

// expected ready vector and channel picks for one cycle
function automatic src_vec_t ref_writeback(
    input  src_vec_t                     we,
    input  reg_addr_t  [N_SRC-1:0]       waddr,
    input  timestamp_t [N_SRC-1:0]       ts,
    input  logic       [TABLE_DEPTH-1:0] tab_valid,
    input  reg_addr_t  [TABLE_DEPTH-1:0] tab_addr,
    input  timestamp_t [TABLE_DEPTH-1:0] tab_ts,
    input  logic                         flush,
    output logic                         g1,
    output int                           s1,
    output logic                         g2,
    output int                           s2
);
    src_vec_t ok;
    src_vec_t rdy;
    ok = we;
    // an older write to the same register still in flight
    for (int s = 0; s < N_SRC; s++) begin
        for (int e = 0; e < TABLE_DEPTH; e++) begin
            if (tab_valid[e] && tab_addr[e] == waddr[s] && tab_ts[e] < ts[s]) begin
                ok[s] = 1'b0;
            end
        end
    end
    // an older requester to the same register in this cycle
    for (int s = 0; s < N_SRC; s++) begin
        for (int j = 0; j < N_SRC; j++) begin
            if (j != s && we[j] && waddr[j] == waddr[s] && ts[j] < ts[s]) begin
                ok[s] = 1'b0;
            end
        end
    end
    g1 = 1'b0;
    g2 = 1'b0;
    s1 = 0;
    s2 = 0;
    rdy = '0;
    if (!flush) begin
        // lsu first, alu last
        for (int s = N_SRC - 1; s >= 0; s--) begin
            if (ok[s] && !g1) begin
                g1 = 1'b1;
                s1 = s;
                rdy[s] = 1'b1;
            end else if (ok[s] && !g2) begin
                g2 = 1'b1;
                s2 = s;
                rdy[s] = 1'b1;
            end
        end
    end
    return rdy;
endfunction

task automatic check_vec(input string what, input src_vec_t exp, input src_vec_t act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
endtask

task automatic check_addr(input string what, input reg_addr_t exp, input reg_addr_t act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
endtask

task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
endtask

task automatic check_commit(input string what, input commit_id_t exp, input commit_id_t act);
    check_count++;
    if (exp !== act) begin
        err_count++;
        $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
endtask

`endif

/* sim/tb_writeback_unit.sv */
// write-back stage testbench
`timescale 1ns/1ps

module tb_writeback_unit;

    import wb_types_pkg::*;
    import wb_src_pkg::*;

    localparam int TABLE_DEPTH = 8;
    localparam time CLK_PERIOD = 40ns;
    localparam int WAIT_LIMIT = 50;
    localparam int DRAIN_LIMIT = 400;
    localparam int RAND_CYCLES = 400;
    localparam logic [31:0] SEED = 32'h0732c97d;

    logic clk = 1'b0;
    logic rst_n;
    logic flush_i = 1'b0;
    src_vec_t src_we_i = '0;
    reg_addr_t  [N_SRC-1:0] src_waddr_i = '0;
    timestamp_t [N_SRC-1:0] src_ts_i = '0;
    reg_data_t  [N_SRC-1:0] src_wdata_i = '0;
    commit_id_t [N_SRC-1:0] src_commit_id_i = '0;
    reg_addr_t  inst1_rd_addr_i = '0;
    reg_addr_t  inst2_rd_addr_i = '0;
    timestamp_t inst1_ts_i = '0;
    timestamp_t inst2_ts_i = '0;
    src_vec_t   src_ready_o;
    logic       reg1_we_o;
    logic       reg2_we_o;
    logic       commit_valid1_o;
    logic       commit_valid2_o;
    reg_addr_t  reg1_waddr_o;
    reg_addr_t  reg2_waddr_o;
    reg_data_t  reg1_wdata_o;
    reg_data_t  reg2_wdata_o;
    commit_id_t commit_id1_o;
    commit_id_t commit_id2_o;

    // stimulus staged by the test process and applied at the next rising edge
    src_vec_t launch_we = '0;
    reg_addr_t  [N_SRC-1:0] launch_waddr = '0;
    timestamp_t [N_SRC-1:0] launch_ts = '0;
    reg_data_t  [N_SRC-1:0] launch_wdata = '0;
    commit_id_t [N_SRC-1:0] launch_cid = '0;
    reg_addr_t  ann1_addr = '0;
    reg_addr_t  ann2_addr = '0;
    timestamp_t ann1_ts = '0;
    timestamp_t ann2_ts = '0;
    logic flush_req = 1'b0;

    // shadow of the in-flight table
    logic       [TABLE_DEPTH-1:0] sh_valid;
    reg_addr_t  [TABLE_DEPTH-1:0] sh_addr;
    timestamp_t [TABLE_DEPTH-1:0] sh_ts;
    logic       [TABLE_DEPTH-1:0] sh_next;
    logic pend1;
    logic pend2;

    logic exp_g1 = 1'b0;
    logic exp_g2 = 1'b0;
    int exp_s1 = 0;
    int exp_s2 = 0;
    src_vec_t exp_ready;

    string cur_test = "none";
    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    int err_at_start = 0;

    timestamp_t q_ts[$];
    reg_addr_t  q_addr[$];
    timestamp_t next_ts;

    `include "wb_ref_model.svh"

    writeback_unit #(.TABLE_DEPTH(TABLE_DEPTH)) writeback_unit_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // input driver
    // ==============================

    always @(posedge clk) begin
        if (rst_n) begin
            src_we_i <= (src_we_i & ~src_ready_o) | launch_we;
            for (int s = 0; s < N_SRC; s++) begin
                if (launch_we[s]) begin
                    src_waddr_i[s]     <= launch_waddr[s];
                    src_ts_i[s]        <= launch_ts[s];
                    src_wdata_i[s]     <= launch_wdata[s];
                    src_commit_id_i[s] <= launch_cid[s];
                end
            end
            inst1_rd_addr_i <= ann1_addr;
            inst1_ts_i      <= ann1_ts;
            inst2_rd_addr_i <= ann2_addr;
            inst2_ts_i      <= ann2_ts;
            flush_i         <= flush_req;
        end
    end

    // shadow table takes the lowest free slot from the old state
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sh_valid <= '0;
        end else if (flush_i) begin
            sh_valid <= '0;
        end else begin
            sh_next = sh_valid;
            pend1 = (inst1_rd_addr_i != '0);
            pend2 = (inst2_rd_addr_i != '0);
            for (int e = 0; e < TABLE_DEPTH; e++) begin
                if (exp_g1 && sh_addr[e] == src_waddr_i[exp_s1] && sh_ts[e] == src_ts_i[exp_s1])
                    sh_next[e] = 1'b0;
                if (exp_g2 && sh_addr[e] == src_waddr_i[exp_s2] && sh_ts[e] == src_ts_i[exp_s2])
                    sh_next[e] = 1'b0;
                if (!sh_valid[e] && pend1) begin
                    sh_next[e] = 1'b1;
                    sh_addr[e] <= inst1_rd_addr_i;
                    sh_ts[e]   <= inst1_ts_i;
                    pend1 = 1'b0;
                end else if (!sh_valid[e] && pend2) begin
                    sh_next[e] = 1'b1;
                    sh_addr[e] <= inst2_rd_addr_i;
                    sh_ts[e]   <= inst2_ts_i;
                    pend2 = 1'b0;
                end
            end
            sh_valid <= sh_next;
        end
    end

    // compare every cycle at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            exp_ready = ref_writeback(src_we_i, src_waddr_i, src_ts_i, sh_valid, sh_addr,
                                      sh_ts, flush_i, exp_g1, exp_s1, exp_g2, exp_s2);
            check_vec("ready", exp_ready, src_ready_o);
            check_bit("reg1_we", exp_g1, reg1_we_o);
            check_bit("reg2_we", exp_g2, reg2_we_o);
            check_bit("commit_valid1", exp_g1, commit_valid1_o);
            check_bit("commit_valid2", exp_g2, commit_valid2_o);
            check_addr("reg1_waddr", exp_g1 ? src_waddr_i[exp_s1] : '0, reg1_waddr_o);
            check_addr("reg2_waddr", exp_g2 ? src_waddr_i[exp_s2] : '0, reg2_waddr_o);
            check_data("reg1_wdata", exp_g1 ? src_wdata_i[exp_s1] : '0, reg1_wdata_o);
            check_data("reg2_wdata", exp_g2 ? src_wdata_i[exp_s2] : '0, reg2_wdata_o);
            check_commit("commit_id1", exp_g1 ? src_commit_id_i[exp_s1] : '0, commit_id1_o);
            check_commit("commit_id2", exp_g2 ? src_commit_id_i[exp_s2] : '0, commit_id2_o);
        end
    end

    // ==============================
    // helpers
    // ==============================

    task automatic next_cycle();
        @(posedge clk);
        #1;
        launch_we = '0;
        ann1_addr = '0;
        ann2_addr = '0;
        flush_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic launch(input int s, input reg_addr_t addr, input timestamp_t ts);
        launch_we[s]    = 1'b1;
        launch_waddr[s] = addr;
        launch_ts[s]    = ts;
        launch_wdata[s] = reg_data_t'($urandom);
        launch_cid[s]   = commit_id_t'($urandom);
    endtask

    task automatic announce(input reg_addr_t a1, input timestamp_t t1,
                            input reg_addr_t a2, input timestamp_t t2);
        ann1_addr = a1;
        ann1_ts   = t1;
        ann2_addr = a2;
        ann2_ts   = t2;
    endtask

    task automatic wait_ready(input src_e src);
        int n;
        n = 0;
        while (!src_ready_o[src] && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!src_ready_o[src]) begin
            err_count++;
            $display("%s: timeout, source %s was never granted", cur_test, src.name());
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((src_we_i != '0 || launch_we != '0) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (src_we_i != '0) begin
            err_count++;
            $display("%s: timeout, requests still pending %b", cur_test, src_we_i);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_at_start = err_count;
        test_count++;
    endtask

    task automatic end_test();
        if (err_count == err_at_start)
            $display("%-12s ok", cur_test);
        else
            $display("%-12s %0d errors", cur_test, err_count - err_at_start);
    endtask

    // one random cycle with issue order kept by the queue
    task automatic random_step(input logic allow_new);
        int room;
        for (int s = 0; s < N_SRC; s++) begin
            if (!src_we_i[s] && q_ts.size() > 0 && ($urandom % 3) != 0)
                launch(s, q_addr.pop_front(), q_ts.pop_front());
        end
        room = TABLE_DEPTH - 1 - $countones(sh_valid) - int'(inst1_rd_addr_i != '0)
               - int'(inst2_rd_addr_i != '0);
        if (allow_new && room >= 1 && next_ts < 250 && ($urandom % 2) == 1) begin
            ann1_addr = reg_addr_t'(1 + $urandom % 6);
            ann1_ts   = next_ts;
            q_addr.push_back(ann1_addr);
            q_ts.push_back(next_ts);
            next_ts++;
            if (room >= 2 && ($urandom % 2) == 1) begin
                ann2_addr = reg_addr_t'(1 + $urandom % 6);
                ann2_ts   = next_ts;
                q_addr.push_back(ann2_addr);
                q_ts.push_back(next_ts);
                next_ts++;
            end
        end
        if (allow_new && ($urandom % 80) == 0)
            flush_req = 1'b1;
        next_cycle();
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        int n;
        void'($urandom(SEED));
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        start_test("reset");
        next_cycle();
        check_vec("ready", '0, src_ready_o);
        check_bit("reg1_we", 1'b0, reg1_we_o);
        check_bit("reg2_we", 1'b0, reg2_we_o);
        check_bit("commit_valid1", 1'b0, commit_valid1_o);
        check_bit("commit_valid2", 1'b0, commit_valid2_o);
        end_test();

        start_test("priority");
        launch(SRC_LSU, 5'd1, 8'd1);
        launch(SRC_DIV, 5'd2, 8'd2);
        launch(SRC_MUL, 5'd3, 8'd3);
        launch(SRC_ALU, 5'd4, 8'd4);
        next_cycle();
        check_vec("ready", 4'b1100, src_ready_o);
        check_addr("reg1_waddr", 5'd1, reg1_waddr_o);
        next_cycle();
        check_vec("ready", 4'b0011, src_ready_o);
        wait_idle();
        end_test();

        start_test("same_cycle");
        launch(SRC_LSU, 5'd5, 8'd9);
        launch(SRC_ALU, 5'd5, 8'd3);
        next_cycle();
        check_vec("ready", 4'b0001, src_ready_o);
        next_cycle();
        check_vec("ready", 4'b1000, src_ready_o);
        wait_idle();
        launch(SRC_LSU, 5'd6, 8'd6);
        launch(SRC_MUL, 5'd6, 8'd6);
        next_cycle();
        check_vec("ready", 4'b1010, src_ready_o);
        check_bit("reg2_we", 1'b1, reg2_we_o);
        wait_idle();
        end_test();

        start_test("inflight");
        announce(5'd7, 8'd5, 5'd7, 8'd9);
        next_cycle();
        launch(SRC_DIV, 5'd7, 8'd9);
        repeat (3) begin
            next_cycle();
            check_bit("div_ready", 1'b0, src_ready_o[SRC_DIV]);
        end
        launch(SRC_MUL, 5'd7, 8'd5);
        next_cycle();
        wait_ready(SRC_MUL);
        check_vec("ready", 4'b0010, src_ready_o);
        next_cycle();
        check_vec("ready", 4'b0100, src_ready_o);
        wait_idle();
        end_test();

        start_test("flush");
        announce(5'd10, 8'd2, 5'd0, 8'd0);
        next_cycle();
        launch(SRC_ALU, 5'd10, 8'd8);
        next_cycle();
        next_cycle();
        check_vec("ready", '0, src_ready_o);
        // fresh request that only the flush holds back
        launch(SRC_LSU, 5'd11, 8'd12);
        flush_req = 1'b1;
        next_cycle();
        check_bit("reg1_we", 1'b0, reg1_we_o);
        check_bit("reg2_we", 1'b0, reg2_we_o);
        check_bit("commit_valid1", 1'b0, commit_valid1_o);
        check_bit("commit_valid2", 1'b0, commit_valid2_o);
        check_vec("ready", '0, src_ready_o);
        next_cycle();
        check_vec("ready", 4'b1001, src_ready_o);
        wait_idle();
        end_test();

        start_test("random");
        next_ts = 8'd20;
        for (int c = 0; c < RAND_CYCLES; c++)
            random_step(1'b1);
        n = 0;
        while ((q_ts.size() > 0 || src_we_i != '0) && n < DRAIN_LIMIT) begin
            random_step(1'b0);
            n++;
        end
        if (q_ts.size() > 0 || src_we_i != '0) begin
            err_count++;
            $display("%s: timeout, random requests did not drain", cur_test);
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+sim
design/wb_types_pkg.sv
design/wb_src_pkg.sv
design/wb_req_if.sv
design/wb_retire_if.sv
design/inflight_table.sv
design/same_cycle_check.sv
design/wb_arbiter.sv
design/writeback_unit.sv
sim/tb_writeback_unit.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_writeback_unit \
    -o sim_wb

./obj_dir/sim_wb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
exit 1
